// File: vlog.f
logic/pool_pkg.sv
logic/pool_if.sv
logic/pool_cfg_regs.sv
logic/map_fetch.sv
logic/ofm_gather.sv
logic/max_pool_unit.sv
logic/pool_top.sv
tb/tb_clk_gen.sv
tb/pool_tb.sv

// File: tb/pool_tb.sv
// Directed testbench for the max-pooling engine.
// Models the map and feature buffers as in-order queues with optional
// random back-pressure and checks every pooled write against a model.

`timescale 1ns/100ps
`default_nettype none

module pool_tb import pool_pkg::*; ();

    localparam int TIMEOUT = 4000;

    logic      clk;
    logic      rst_n;
    logic      cfg_vld;
    logic      cfg_rdy;
    idx_t      cfg_nip;
    cnt_t      cfg_k;
    idx_t      cfg_chn_grp;
    idx_t      cfg_map_base;
    idx_t      cfg_ofm_rd_base;
    idx_t      cfg_ofm_wr_base;
    idx_t      map_rd_addr;
    logic      map_rd_addr_vld;
    logic      map_rd_addr_rdy;
    map_word_t map_rd_dat;
    logic      map_rd_dat_vld;
    logic      map_rd_dat_rdy;
    idx_t      ofm_rd_addr;
    logic      ofm_rd_addr_vld;
    logic      ofm_rd_addr_rdy;
    row_t      ofm_rd_dat;
    logic      ofm_rd_dat_vld;
    logic      ofm_rd_dat_rdy;
    idx_t      ofm_wr_addr;
    row_t      ofm_wr_dat;
    logic      ofm_wr_vld;
    logic      ofm_wr_rdy;

    // Buffer contents and in-flight read data
    map_word_t map_mem [0:1023];
    row_t      feat_mem [0:8191];
    map_word_t map_q[$];
    row_t      feat_q[$];

    // Expected reads and writes, in point then group order
    idx_t      exp_map_q[$];
    idx_t      exp_rd_q[$];
    idx_t      exp_addr_q[$];
    row_t      exp_row_q[$];

    logic      wr_held;
    idx_t      held_addr;
    row_t      held_dat;
    logic      stall_en;
    integer    seed;

    tb_clk_gen #(.PERIOD(8.0), .RST_CYCLES(2)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pool_top dut0 (
        .clk (clk), .rst_n (rst_n),
        .cfg_vld (cfg_vld), .cfg_rdy (cfg_rdy),
        .cfg_nip (cfg_nip), .cfg_k (cfg_k), .cfg_chn_grp (cfg_chn_grp),
        .cfg_map_base (cfg_map_base), .cfg_ofm_rd_base (cfg_ofm_rd_base),
        .cfg_ofm_wr_base (cfg_ofm_wr_base),
        .map_rd_addr (map_rd_addr), .map_rd_addr_vld (map_rd_addr_vld),
        .map_rd_addr_rdy (map_rd_addr_rdy), .map_rd_dat (map_rd_dat),
        .map_rd_dat_vld (map_rd_dat_vld), .map_rd_dat_rdy (map_rd_dat_rdy),
        .ofm_rd_addr (ofm_rd_addr), .ofm_rd_addr_vld (ofm_rd_addr_vld),
        .ofm_rd_addr_rdy (ofm_rd_addr_rdy), .ofm_rd_dat (ofm_rd_dat),
        .ofm_rd_dat_vld (ofm_rd_dat_vld), .ofm_rd_dat_rdy (ofm_rd_dat_rdy),
        .ofm_wr_addr (ofm_wr_addr), .ofm_wr_dat (ofm_wr_dat),
        .ofm_wr_vld (ofm_wr_vld), .ofm_wr_rdy (ofm_wr_rdy)
    );

    // ==============================
    // Failure reporting and checks
    // ==============================
    task automatic stop_failed(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Simulation FAILED");
        $fatal(1, "stopping after first error");
    endtask

    task automatic check_row(input string name, input row_t got, input row_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_failed({"mismatch on ", name});
        end
    endtask

    task automatic check_idx(input string name, input idx_t got, input idx_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_failed({"mismatch on ", name});
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_failed({"mismatch on ", name});
        end
    endtask

    // ==============================
    // Buffer models
    // ==============================
    always @(posedge clk) begin
        if (map_rd_dat_vld && map_rd_dat_rdy) void'(map_q.pop_front());
        if (map_rd_addr_vld && map_rd_addr_rdy) begin
            if (exp_map_q.size() == 0) stop_failed("map read issued with none expected");
            check_idx("map_rd_addr", map_rd_addr, exp_map_q.pop_front());
            map_q.push_back(map_mem[map_rd_addr]);
        end
        if (ofm_rd_dat_vld && ofm_rd_dat_rdy) void'(feat_q.pop_front());
        if (ofm_rd_addr_vld && ofm_rd_addr_rdy) begin
            if (exp_rd_q.size() == 0) stop_failed("feature read issued with none expected");
            check_idx("ofm_rd_addr", ofm_rd_addr, exp_rd_q.pop_front());
            feat_q.push_back(feat_mem[ofm_rd_addr]);
        end
        #1;
        // Ready and valid throttled about one cycle in four when stalling
        map_rd_addr_rdy = !stall_en || ($random(seed) % 4 != 0);
        ofm_rd_addr_rdy = !stall_en || ($random(seed) % 4 != 0);
        ofm_wr_rdy      = !stall_en || ($random(seed) % 4 != 0);
        map_rd_dat_vld  = (map_q.size() != 0) && (!stall_en || ($random(seed) % 4 != 0));
        ofm_rd_dat_vld  = (feat_q.size() != 0) && (!stall_en || ($random(seed) % 4 != 0));
        if (map_q.size() != 0) map_rd_dat = map_q[0];
        if (feat_q.size() != 0) ofm_rd_dat = feat_q[0];
    end

    // Write port monitor, including payload hold under back-pressure
    always @(posedge clk) begin
        if (wr_held) begin
            check_bit("ofm_wr_vld", ofm_wr_vld, 1'b1);
            check_idx("ofm_wr_addr", ofm_wr_addr, held_addr);
            check_row("ofm_wr_dat", ofm_wr_dat, held_dat);
        end
        wr_held   = ofm_wr_vld && !ofm_wr_rdy;
        held_addr = ofm_wr_addr;
        held_dat  = ofm_wr_dat;
        if (ofm_wr_vld && ofm_wr_rdy) begin
            if (exp_addr_q.size() == 0) stop_failed("write accepted with none expected");
            check_idx("ofm_wr_addr", ofm_wr_addr, exp_addr_q.pop_front());
            check_row("ofm_wr_dat", ofm_wr_dat, exp_row_q.pop_front());
        end
    end

    // ==============================
    // Reference model and run control
    // ==============================
    function automatic pool_cfg_t make_cfg(input int nip, k, chn_grp, map_base,
                                           rd_base, wr_base);
        pool_cfg_t c;
        c.nip         = idx_t'(nip);
        c.k           = cnt_t'(k);
        c.chn_grp     = idx_t'(chn_grp);
        c.map_base    = idx_t'(map_base);
        c.ofm_rd_base = idx_t'(rd_base);
        c.ofm_wr_base = idx_t'(wr_base);
        return c;
    endfunction

    task automatic expect_run(input pool_cfg_t c);
        row_t m;
        row_t r;
        idx_t a;
        for (int p = 0; p < c.nip; p++) begin
            exp_map_q.push_back(idx_t'(c.map_base + p));
            for (int g = 0; g < c.chn_grp; g++) begin
                for (int n = 0; n < c.k; n++) begin
                    a = c.ofm_rd_base + map_mem[c.map_base + p][n] * c.chn_grp + g;
                    exp_rd_q.push_back(a);
                    r = feat_mem[a];
                    for (int l = 0; l < NUM_LANES; l++) begin
                        if (n == 0 || r[l] > m[l]) m[l] = r[l];
                    end
                end
                exp_addr_q.push_back(idx_t'(c.ofm_wr_base + p * c.chn_grp + g));
                exp_row_q.push_back(m);
            end
        end
    endtask

    task automatic send_config(input pool_cfg_t c);
        int t;
        t = 0;
        @(posedge clk);
        #1;
        cfg_nip         = c.nip;
        cfg_k           = c.k;
        cfg_chn_grp     = c.chn_grp;
        cfg_map_base    = c.map_base;
        cfg_ofm_rd_base = c.ofm_rd_base;
        cfg_ofm_wr_base = c.ofm_wr_base;
        cfg_vld         = 1'b1;
        @(posedge clk);
        while (!cfg_rdy) begin
            t++;
            if (t > TIMEOUT) stop_failed("timeout waiting for cfg_rdy");
            @(posedge clk);
        end
        #1;
        cfg_vld = 1'b0;
    endtask

    // Returns on the first falling edge after the last expected write
    task automatic wait_run_done();
        int t;
        t = 0;
        while (exp_addr_q.size() != 0) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) stop_failed("timeout waiting for the pooled writes");
        end
        check_bit("cfg_rdy", cfg_rdy, 1'b1);
    endtask

    task automatic run_and_check(input pool_cfg_t c);
        expect_run(c);
        send_config(c);
        wait_run_done();
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset_values();
        int t;
        t = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            t++;
            if (t > 20) stop_failed("reset was never released");
        end
        @(negedge clk);
        check_bit("cfg_rdy", cfg_rdy, 1'b1);
        check_bit("map_rd_addr_vld", map_rd_addr_vld, 1'b0);
        check_bit("ofm_rd_addr_vld", ofm_rd_addr_vld, 1'b0);
        check_bit("ofm_wr_vld", ofm_wr_vld, 1'b0);
        check_bit("map_rd_dat_rdy", map_rd_dat_rdy, 1'b0);
        check_bit("ofm_rd_dat_rdy", ofm_rd_dat_rdy, 1'b0);
    endtask

    task automatic test_single_neighbor();
        map_mem[16'h0300][0] = 16'd7;
        exp_map_q.push_back(16'h0300);
        exp_rd_q.push_back(16'h1000 + 16'd7);
        exp_addr_q.push_back(16'h4000);
        exp_row_q.push_back(feat_mem[16'h1000 + 7]);
        send_config(make_cfg(1, 1, 1, 16'h0300, 16'h1000, 16'h4000));
        wait_run_done();
    endtask

    task automatic test_full_map();
        run_and_check(make_cfg(5, MAP_ENTRIES, 3, 16'h0100, 16'h1000, 16'h0800));
    endtask

    task automatic test_stalls();
        stall_en = 1'b1;
        run_and_check(make_cfg(5, MAP_ENTRIES, 3, 16'h0100, 16'h1000, 16'h0800));
        stall_en = 1'b0;
    endtask

    task automatic test_busy_config();
        pool_cfg_t c;
        c = make_cfg(4, 5, 2, 16'h0200, 16'h1000, 16'h0900);
        expect_run(c);
        send_config(c);
        // Stray configuration one cycle into the run
        cfg_nip         = 16'd9;
        cfg_k           = cnt_t'(2);
        cfg_chn_grp     = 16'd1;
        cfg_ofm_wr_base = 16'hF000;
        cfg_vld         = 1'b1;
        @(posedge clk);
        check_bit("cfg_rdy", cfg_rdy, 1'b0);
        #1;
        cfg_vld = 1'b0;
        wait_run_done();
        run_and_check(make_cfg(3, 3, 4, 16'h0280, 16'h1400, 16'h0A00));
    endtask

    initial begin
        seed            = 15;
        stall_en        = 1'b0;
        wr_held         = 1'b0;
        cfg_vld         = 1'b0;
        cfg_nip         = '0;
        cfg_k           = '0;
        cfg_chn_grp     = '0;
        cfg_map_base    = '0;
        cfg_ofm_rd_base = '0;
        cfg_ofm_wr_base = '0;
        map_rd_addr_rdy = 1'b0;
        map_rd_dat      = '0;
        map_rd_dat_vld  = 1'b0;
        ofm_rd_addr_rdy = 1'b0;
        ofm_rd_dat      = '0;
        ofm_rd_dat_vld  = 1'b0;
        ofm_wr_rdy      = 1'b0;
        // Neighbor indices limited to 64 points
        for (int a = 0; a < 1024; a++) begin
            for (int n = 0; n < MAP_ENTRIES; n++) begin
                map_mem[a][n] = idx_t'($random(seed) & 63);
            end
        end
        for (int a = 0; a < 8192; a++) begin
            feat_mem[a] = row_t'($random(seed));
        end

        test_reset_values();
        test_single_neighbor();
        test_full_map();
        test_stalls();
        test_busy_config();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
// Clock and reset source for the pooling testbench.
// rst_n is held low for the first RST_CYCLES rising edges.

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD     = 8.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // Release just after an edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: logic/pool_top.sv
// Top level of the point-cloud max-pooling engine.
// Configuration and global-buffer ports are plain valid/ready ports;
// internally the core splits into config, map fetch, gather and pooling.

`timescale 1ns/100ps
`default_nettype none

module pool_top import pool_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // Configuration
    input  logic       cfg_vld,
    output logic       cfg_rdy,
    input  idx_t       cfg_nip,
    input  cnt_t       cfg_k,
    input  idx_t       cfg_chn_grp,
    input  idx_t       cfg_map_base,
    input  idx_t       cfg_ofm_rd_base,
    input  idx_t       cfg_ofm_wr_base,
    // Map read
    output idx_t       map_rd_addr,
    output logic       map_rd_addr_vld,
    input  logic       map_rd_addr_rdy,
    input  map_word_t  map_rd_dat,
    input  logic       map_rd_dat_vld,
    output logic       map_rd_dat_rdy,
    // Feature read
    output idx_t       ofm_rd_addr,
    output logic       ofm_rd_addr_vld,
    input  logic       ofm_rd_addr_rdy,
    input  row_t       ofm_rd_dat,
    input  logic       ofm_rd_dat_vld,
    output logic       ofm_rd_dat_rdy,
    // Pooled write
    output idx_t       ofm_wr_addr,
    output row_t       ofm_wr_dat,
    output logic       ofm_wr_vld,
    input  logic       ofm_wr_rdy
);

    pool_cfg_t cfg_in;

    pool_cfg_if cfg_bus ();
    nbr_if      nbr ();

    assign cfg_in = '{
        nip:         cfg_nip,
        k:           cfg_k,
        chn_grp:     cfg_chn_grp,
        map_base:    cfg_map_base,
        ofm_rd_base: cfg_ofm_rd_base,
        ofm_wr_base: cfg_ofm_wr_base
    };

    pool_cfg_regs u_cfg_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_vld (cfg_vld),
        .cfg_rdy (cfg_rdy),
        .cfg_in  (cfg_in),
        .cfg_bus (cfg_bus.regs)
    );

    map_fetch u_map_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_bus         (cfg_bus.user),
        .map_rd_addr     (map_rd_addr),
        .map_rd_addr_vld (map_rd_addr_vld),
        .map_rd_addr_rdy (map_rd_addr_rdy),
        .map_rd_dat      (map_rd_dat),
        .map_rd_dat_vld  (map_rd_dat_vld),
        .map_rd_dat_rdy  (map_rd_dat_rdy),
        .nbr             (nbr.src)
    );

    ofm_gather u_ofm_gather (
        .cfg_bus         (cfg_bus.user),
        .nbr             (nbr.dst),
        .ofm_rd_addr     (ofm_rd_addr),
        .ofm_rd_addr_vld (ofm_rd_addr_vld),
        .ofm_rd_addr_rdy (ofm_rd_addr_rdy)
    );

    max_pool_unit #(
        .NUM_LANES (NUM_LANES)
    ) u_max_pool (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_bus        (cfg_bus.user),
        .ofm_rd_dat     (ofm_rd_dat),
        .ofm_rd_dat_vld (ofm_rd_dat_vld),
        .ofm_rd_dat_rdy (ofm_rd_dat_rdy),
        .ofm_wr_addr    (ofm_wr_addr),
        .ofm_wr_dat     (ofm_wr_dat),
        .ofm_wr_vld     (ofm_wr_vld),
        .ofm_wr_rdy     (ofm_wr_rdy)
    );

endmodule

`default_nettype wire

// File: logic/max_pool_unit.sv
// Lane-wise max pooling over k feature rows and result write-back.
// Rows arrive in (point, group, neighbor) order; each block of k rows
// gives one output row written at base + point * chn_grp + group.
// done pulses with the handshake of the final write of a run.

`timescale 1ns/100ps
`default_nettype none

module max_pool_unit import pool_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    pool_cfg_if.user   cfg_bus,
    input  row_t       ofm_rd_dat,
    input  logic       ofm_rd_dat_vld,
    output logic       ofm_rd_dat_rdy,
    output idx_t       ofm_wr_addr,
    output row_t       ofm_wr_dat,
    output logic       ofm_wr_vld,
    input  logic       ofm_wr_rdy
);

    row_t acc;
    row_t acc_next;
    cnt_t row_cnt;
    idx_t grp_cnt;
    idx_t pt_cnt;
    logic res_vld;
    logic rd_hs;
    logic wr_hs;
    logic last_row;
    logic last_grp;
    logic last_pt;

    assign rd_hs    = ofm_rd_dat_vld && ofm_rd_dat_rdy;
    assign wr_hs    = res_vld && ofm_wr_rdy;
    assign last_row = (row_cnt == cfg_bus.cfg.k - cnt_t'(1));
    assign last_grp = (grp_cnt == cfg_bus.cfg.chn_grp - idx_t'(1));
    assign last_pt  = (pt_cnt == cfg_bus.cfg.nip - idx_t'(1));

    // No new rows while a result waits for the write port
    assign ofm_rd_dat_rdy = cfg_bus.busy && !res_vld;

    assign ofm_wr_vld   = res_vld;
    assign ofm_wr_dat   = acc;
    assign ofm_wr_addr  = cfg_bus.cfg.ofm_wr_base + pt_cnt * cfg_bus.cfg.chn_grp + grp_cnt;
    assign cfg_bus.done = wr_hs && last_grp && last_pt;

    // ==============================
    // Lane compare
    // ==============================
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            acc_next[i] = (ofm_rd_dat[i] > acc[i]) ? ofm_rd_dat[i] : acc[i];
        end
    end

    // First row of a block loads, the rest compare
    always_ff @(posedge clk) begin
        if (rd_hs) acc <= (row_cnt == '0) ? ofm_rd_dat : acc_next;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt <= '0;
            grp_cnt <= '0;
            pt_cnt  <= '0;
            res_vld <= 1'b0;
        end else if (cfg_bus.start) begin
            row_cnt <= '0;
            grp_cnt <= '0;
            pt_cnt  <= '0;
            res_vld <= 1'b0;
        end else begin
            if (rd_hs) begin
                row_cnt <= last_row ? '0 : row_cnt + cnt_t'(1);
                if (last_row) res_vld <= 1'b1;
            end
            if (wr_hs) begin
                res_vld <= 1'b0;
                grp_cnt <= last_grp ? '0 : grp_cnt + idx_t'(1);
                if (last_grp) pt_cnt <= pt_cnt + idx_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/ofm_gather.sv
// Feature-row address generation for the buffer read port.
// Feature rows are stored point-major, one row per channel group,
// so a neighbor's row sits at base + idx * chn_grp + grp.
// Purely combinational; handshake passes straight through.

`timescale 1ns/100ps
`default_nettype none

module ofm_gather import pool_pkg::*; (
    pool_cfg_if.user   cfg_bus,
    nbr_if.dst         nbr,
    output idx_t       ofm_rd_addr,
    output logic       ofm_rd_addr_vld,
    input  logic       ofm_rd_addr_rdy
);

    idx_t row_ofs;

    // Offset of the neighbor's first group
    assign row_ofs = nbr.idx * cfg_bus.cfg.chn_grp;

    assign ofm_rd_addr     = cfg_bus.cfg.ofm_rd_base + row_ofs + nbr.grp;
    assign ofm_rd_addr_vld = nbr.vld;

    // Stream stalls whenever the buffer refuses the address
    assign nbr.rdy = ofm_rd_addr_rdy;

endmodule

`default_nettype wire

// File: logic/map_fetch.sv
// Map reader and neighbor walker.
// Per center point one map word is read; its first k indices are then
// presented once per channel group on the neighbor stream.

`timescale 1ns/100ps
`default_nettype none

module map_fetch import pool_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    pool_cfg_if.user   cfg_bus,
    output idx_t       map_rd_addr,
    output logic       map_rd_addr_vld,
    input  logic       map_rd_addr_rdy,
    input  map_word_t  map_rd_dat,
    input  logic       map_rd_dat_vld,
    output logic       map_rd_dat_rdy,
    nbr_if.src         nbr
);

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA,
        FETCH_NBR
    } fetch_state_e;

    fetch_state_e state;
    map_word_t    map_q;
    idx_t         pt_cnt;
    idx_t         grp_cnt;
    cnt_t         nbr_cnt;
    logic         last_nbr;
    logic         last_grp;
    logic         last_pt;

    assign last_nbr = (nbr_cnt == cfg_bus.cfg.k - cnt_t'(1));
    assign last_grp = (grp_cnt == cfg_bus.cfg.chn_grp - idx_t'(1));
    assign last_pt  = (pt_cnt == cfg_bus.cfg.nip - idx_t'(1));

    assign map_rd_addr     = cfg_bus.cfg.map_base + pt_cnt;
    assign map_rd_addr_vld = (state == FETCH_ADDR);
    assign map_rd_dat_rdy  = (state == FETCH_DATA);

    assign nbr.vld = (state == FETCH_NBR);
    assign nbr.idx = map_q[nbr_cnt];
    assign nbr.grp = grp_cnt;

    // ==============================
    // Point / group / neighbor walk
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= FETCH_IDLE;
            pt_cnt  <= '0;
            grp_cnt <= '0;
            nbr_cnt <= '0;
        end else if (cfg_bus.start) begin
            state   <= FETCH_ADDR;
            pt_cnt  <= '0;
        end else begin
            case (state)
                FETCH_ADDR: if (map_rd_addr_rdy) state <= FETCH_DATA;
                FETCH_DATA: begin
                    if (map_rd_dat_vld) begin
                        state   <= FETCH_NBR;
                        grp_cnt <= '0;
                        nbr_cnt <= '0;
                    end
                end
                FETCH_NBR: begin
                    if (nbr.rdy) begin
                        nbr_cnt <= last_nbr ? '0 : nbr_cnt + cnt_t'(1);
                        if (last_nbr) begin
                            grp_cnt <= last_grp ? '0 : grp_cnt + idx_t'(1);
                        end
                        // Next point once every group has been walked
                        if (last_nbr && last_grp) begin
                            state  <= last_pt ? FETCH_IDLE : FETCH_ADDR;
                            pt_cnt <= pt_cnt + idx_t'(1);
                        end
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (map_rd_dat_vld && map_rd_dat_rdy) map_q <= map_rd_dat;
    end

endmodule

`default_nettype wire

// File: logic/pool_cfg_regs.sv
// Configuration register and run state of the pooling core.
// A configuration is taken only while idle; busy holds until the
// pooling unit reports the last write.

`timescale 1ns/100ps
`default_nettype none

module pool_cfg_regs import pool_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_vld,
    output logic       cfg_rdy,
    input  pool_cfg_t  cfg_in,
    pool_cfg_if.regs   cfg_bus
);

    pool_state_e state;

    assign cfg_rdy      = (state == IDLE);
    assign cfg_bus.busy = (state == RUN);

    // ==============================
    // Run state
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            cfg_bus.start <= 1'b0;
        end else begin
            cfg_bus.start <= 1'b0;
            case (state)
                IDLE: begin
                    if (cfg_vld) begin
                        state         <= RUN;
                        cfg_bus.start <= 1'b1;
                    end
                end
                RUN: begin
                    if (cfg_bus.done) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Captured once per run
    always_ff @(posedge clk) begin
        if (cfg_vld && cfg_rdy) cfg_bus.cfg <= cfg_in;
    end

endmodule

`default_nettype wire

// File: logic/pool_if.sv
// Interfaces used between the blocks of the pooling core.
// pool_cfg_if carries the active configuration and run control,
// nbr_if carries the neighbor-index stream to the feature-read port.

`timescale 1ns/100ps
`default_nettype none

interface pool_cfg_if import pool_pkg::*; ();

    pool_cfg_t cfg;
    logic      busy;
    // One-cycle pulse at the start of a run
    logic      start;
    // One-cycle pulse with the last write handshake
    logic      done;

    modport regs (
        output cfg,
        output busy,
        output start,
        input  done
    );

    modport user (
        input  cfg,
        input  busy,
        input  start,
        output done
    );

endinterface

interface nbr_if import pool_pkg::*; ();

    logic vld;
    logic rdy;
    idx_t idx;
    idx_t grp;

    modport src (output vld, output idx, output grp, input rdy);
    modport dst (input vld, input idx, input grp, output rdy);

endinterface

`default_nettype wire

// File: logic/pool_pkg.sv
// Shared widths, data types and configuration record of the pooling engine.
// Import with a wildcard in the header of any module or interface that
// needs one of these definitions.

`default_nettype none

package pool_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int ACT_WIDTH   = 8;
    localparam int NUM_LANES   = 4;
    localparam int IDX_WIDTH   = 16;
    localparam int MAP_ENTRIES = 8;
    // Must hold MAP_ENTRIES itself, not only MAP_ENTRIES-1
    localparam int CNT_WIDTH   = $clog2(MAP_ENTRIES + 1);

    // ==============================
    // Data types
    // ==============================
    typedef logic [ACT_WIDTH-1:0] act_t;
    typedef logic [IDX_WIDTH-1:0] idx_t;
    typedef act_t [NUM_LANES-1:0] row_t;
    // Entry 0 in the low bits
    typedef idx_t [MAP_ENTRIES-1:0] map_word_t;
    typedef logic [CNT_WIDTH-1:0] cnt_t;

    typedef struct packed {
        idx_t nip;
        cnt_t k;
        idx_t chn_grp;
        idx_t map_base;
        idx_t ofm_rd_base;
        idx_t ofm_wr_base;
    } pool_cfg_t;

    typedef enum logic {
        IDLE,
        RUN
    } pool_state_e;

endpackage

`default_nettype wire
